// File: hw/cache_pkg.sv
package cache_pkg;

	localparam int WORD_W      = 16;
	localparam int ADDR_W      = 16;
	localparam int MEM_WORDS   = 256;
	localparam int LINE_NUM    = 8;
	localparam int LINE_WORDS  = 4;
	localparam int TAG_W       = 11;
	localparam int INDEX_W     = 3;
	localparam int OFFS_W      = 2;
	localparam int MEM_LATENCY = 4;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef word_t [LINE_WORDS-1:0] line_t;
	// tag joined with index
	typedef logic [TAG_W+INDEX_W-1:0] line_addr_t;

	typedef struct packed {
		addr_t addr;
	} ireq_t;

	typedef struct packed {
		addr_t addr;
		word_t wdata;
		logic  write;
	} dreq_t;

	typedef struct packed {
		line_addr_t line_addr;
		logic       write;
		line_t      line;
	} mem_req_t;

	// address splits into tag, index and word offset
	function automatic tag_t get_tag(addr_t a);
		return a[ADDR_W-1 -: TAG_W];
	endfunction

	function automatic index_t get_index(addr_t a);
		return a[OFFS_W +: INDEX_W];
	endfunction

	function automatic logic [OFFS_W-1:0] get_offs(addr_t a);
		return a[OFFS_W-1:0];
	endfunction

endpackage

// File: hw/icache.sv
`timescale 1ns/10ps
module icache (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                i_ireq_valid,
	input  cache_pkg::ireq_t    i_ireq,
	output logic                o_irsp_valid,
	output cache_pkg::word_t    o_irsp_data,
	output logic                o_ibusy,
	output logic                o_mem_req_valid,
	output cache_pkg::mem_req_t o_mem_req,
	input  logic                i_mem_done,
	input  cache_pkg::line_t    i_mem_line
);
	import cache_pkg::*;

	tag_t  tag_arr  [LINE_NUM];
	line_t data_arr [LINE_NUM];
	logic [LINE_NUM-1:0] valid_arr;

	tag_t   req_tag;
	index_t req_index;
	logic [OFFS_W-1:0] req_offs;
	logic   hit;
	logic   accept;
	logic   miss;
	index_t fill_index;
	tag_t   fill_tag;

	assign req_tag   = get_tag(i_ireq.addr);
	assign req_index = get_index(i_ireq.addr);
	assign req_offs  = get_offs(i_ireq.addr);
	assign hit       = valid_arr[req_index] && (tag_arr[req_index] == req_tag);
	assign accept    = i_ireq_valid && !o_ibusy && hit;
	assign miss      = i_ireq_valid && !o_ibusy && !hit;

	// the outstanding request still names the line being filled
	assign fill_index = o_mem_req.line_addr[INDEX_W-1:0];
	assign fill_tag   = o_mem_req.line_addr[INDEX_W +: TAG_W];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid_arr       <= '0;
			o_ibusy         <= 1'b0;
			o_irsp_valid    <= 1'b0;
			o_mem_req_valid <= 1'b0;
		end else begin
			o_irsp_valid    <= accept;
			o_mem_req_valid <= miss;
			if (miss) begin
				o_ibusy <= 1'b1;
			end else if (i_mem_done) begin
				o_ibusy <= 1'b0;
			end
			if (i_mem_done) begin
				valid_arr[fill_index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			o_irsp_data <= data_arr[req_index][req_offs];
		end
		// read-only side, so every line request is a fetch
		if (miss) begin
			o_mem_req <= '{line_addr: {req_tag, req_index}, write: 1'b0, line: '0};
		end
		if (i_mem_done) begin
			tag_arr[fill_index]  <= fill_tag;
			data_arr[fill_index] <= i_mem_line;
		end
	end

endmodule

// File: hw/dcache.sv
`timescale 1ns/10ps
module dcache (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                i_dreq_valid,
	input  cache_pkg::dreq_t    i_dreq,
	output logic                o_drsp_valid,
	output cache_pkg::word_t    o_drsp_data,
	output logic                o_dbusy,
	output logic                o_mem_req_valid,
	output cache_pkg::mem_req_t o_mem_req,
	input  logic                i_mem_done,
	input  cache_pkg::line_t    i_mem_line
);
	import cache_pkg::*;

	tag_t  tag_arr  [LINE_NUM];
	line_t data_arr [LINE_NUM];
	logic [LINE_NUM-1:0] valid_arr;
	logic [LINE_NUM-1:0] dirty_arr;

	tag_t   req_tag;
	index_t req_index;
	logic [OFFS_W-1:0] req_offs;
	logic   hit;
	logic   accept;
	logic   miss;
	logic   victim_dirty;
	index_t fill_index;
	tag_t   fill_tag;
	logic   wb_done;
	logic   refill_done;

	assign req_tag   = get_tag(i_dreq.addr);
	assign req_index = get_index(i_dreq.addr);
	assign req_offs  = get_offs(i_dreq.addr);
	assign hit       = valid_arr[req_index] && (tag_arr[req_index] == req_tag);
	assign accept    = i_dreq_valid && !o_dbusy && hit;
	assign miss      = i_dreq_valid && !o_dbusy && !hit;

	assign victim_dirty = valid_arr[req_index] && dirty_arr[req_index];

	assign fill_index  = o_mem_req.line_addr[INDEX_W-1:0];
	assign fill_tag    = o_mem_req.line_addr[INDEX_W +: TAG_W];
	assign wb_done     = i_mem_done && o_mem_req.write;
	assign refill_done = i_mem_done && !o_mem_req.write;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid_arr       <= '0;
			dirty_arr       <= '0;
			o_dbusy         <= 1'b0;
			o_drsp_valid    <= 1'b0;
			o_mem_req_valid <= 1'b0;
		end else begin
			// a write hit answers with a plain ack
			o_drsp_valid    <= accept;
			o_mem_req_valid <= miss;
			if (miss) begin
				o_dbusy <= 1'b1;
			end else if (i_mem_done) begin
				o_dbusy <= 1'b0;
			end

			if (accept && i_dreq.write) begin
				dirty_arr[req_index] <= 1'b1;
			end
			// after a writeback the line stays valid but clean,
			// and the held request misses again into a refill
			if (wb_done) begin
				dirty_arr[fill_index] <= 1'b0;
			end
			if (refill_done) begin
				valid_arr[fill_index] <= 1'b1;
				dirty_arr[fill_index] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			o_drsp_data <= data_arr[req_index][req_offs];
			if (i_dreq.write) begin
				data_arr[req_index][req_offs] <= i_dreq.wdata;
			end
		end

		if (miss) begin
			if (victim_dirty) begin
				// old line goes back to its own address
				o_mem_req <= '{
					line_addr: {tag_arr[req_index], req_index},
					write:     1'b1,
					line:      data_arr[req_index]
				};
			end else begin
				o_mem_req <= '{line_addr: {req_tag, req_index}, write: 1'b0, line: '0};
			end
		end

		if (refill_done) begin
			tag_arr[fill_index]  <= fill_tag;
			data_arr[fill_index] <= i_mem_line;
		end
	end

endmodule

// File: hw/line_memory.sv
`timescale 1ns/10ps
module line_memory (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                i_ireq_valid,
	input  cache_pkg::mem_req_t i_ireq,
	output logic                o_idone,
	output cache_pkg::line_t    o_iline,
	input  logic                i_dreq_valid,
	input  cache_pkg::mem_req_t i_dreq,
	output logic                o_ddone,
	output cache_pkg::line_t    o_dline
);
	import cache_pkg::*;

	typedef logic [$clog2(MEM_WORDS)-1:0] maddr_t;
	typedef logic [$clog2(MEM_LATENCY)-1:0] cnt_t;

	word_t mem [MEM_WORDS];

	// port 0 serves the instruction side, port 1 the data side
	mem_req_t req_in [2];
	mem_req_t req_q  [2];
	logic [1:0] req_valid;
	cnt_t  cnt    [2];
	logic [1:0] done_q;
	line_t line_q [2];

	// the array decodes only the low address bits
	function automatic maddr_t word_addr(line_addr_t la, int w);
		logic [TAG_W+INDEX_W+OFFS_W-1:0] full;
		full = {la, OFFS_W'(w)};
		return full[$bits(maddr_t)-1:0];
	endfunction

	initial begin
		$readmemh("hw/mem_init.hex", mem);
	end

	assign req_in[0] = i_ireq;
	assign req_in[1] = i_dreq;
	assign req_valid = {i_dreq_valid, i_ireq_valid};
	assign o_idone   = done_q[0];
	assign o_iline   = line_q[0];
	assign o_ddone   = done_q[1];
	assign o_dline   = line_q[1];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cnt[0] <= '0;
			cnt[1] <= '0;
			done_q <= '0;
		end else begin
			for (int p = 0; p < 2; p++) begin
				// cnt reaches 1 in the cycle before done
				done_q[p] <= (cnt[p] == cnt_t'(1));
				if (req_valid[p]) begin
					cnt[p] <= cnt_t'(MEM_LATENCY - 1);
				end else if (cnt[p] != '0) begin
					cnt[p] <= cnt[p] - cnt_t'(1);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int p = 0; p < 2; p++) begin
			if (req_valid[p]) begin
				req_q[p] <= req_in[p];
			end
			if (cnt[p] == cnt_t'(1)) begin
				for (int w = 0; w < LINE_WORDS; w++) begin
					if (req_q[p].write) begin
						mem[word_addr(req_q[p].line_addr, w)] <= req_q[p].line[w];
					end else begin
						line_q[p][w] <= mem[word_addr(req_q[p].line_addr, w)];
					end
				end
			end
		end
	end

endmodule

// File: hw/split_cache_top.sv
`timescale 1ns/10ps
module split_cache_top (
	input  logic             clk,
	input  logic             reset_n,
	input  logic             i_ireq_valid,
	input  cache_pkg::ireq_t i_ireq,
	output logic             o_irsp_valid,
	output cache_pkg::word_t o_irsp_data,
	output logic             o_ibusy,
	input  logic             i_dreq_valid,
	input  cache_pkg::dreq_t i_dreq,
	output logic             o_drsp_valid,
	output cache_pkg::word_t o_drsp_data,
	output logic             o_dbusy
);
	import cache_pkg::*;

	logic     imem_req_valid;
	mem_req_t imem_req;
	logic     imem_done;
	line_t    imem_line;

	logic     dmem_req_valid;
	mem_req_t dmem_req;
	logic     dmem_done;
	line_t    dmem_line;

	icache u_icache (
		.clk             (clk),
		.reset_n         (reset_n),
		.i_ireq_valid    (i_ireq_valid),
		.i_ireq          (i_ireq),
		.o_irsp_valid    (o_irsp_valid),
		.o_irsp_data     (o_irsp_data),
		.o_ibusy         (o_ibusy),
		.o_mem_req_valid (imem_req_valid),
		.o_mem_req       (imem_req),
		.i_mem_done      (imem_done),
		.i_mem_line      (imem_line)
	);

	dcache u_dcache (
		.clk             (clk),
		.reset_n         (reset_n),
		.i_dreq_valid    (i_dreq_valid),
		.i_dreq          (i_dreq),
		.o_drsp_valid    (o_drsp_valid),
		.o_drsp_data     (o_drsp_data),
		.o_dbusy         (o_dbusy),
		.o_mem_req_valid (dmem_req_valid),
		.o_mem_req       (dmem_req),
		.i_mem_done      (dmem_done),
		.i_mem_line      (dmem_line)
	);

	line_memory u_line_memory (
		.clk          (clk),
		.reset_n      (reset_n),
		.i_ireq_valid (imem_req_valid),
		.i_ireq       (imem_req),
		.o_idone      (imem_done),
		.o_iline      (imem_line),
		.i_dreq_valid (dmem_req_valid),
		.i_dreq       (dmem_req),
		.o_ddone      (dmem_done),
		.o_dline      (dmem_line)
	);

endmodule

// File: tb/split_cache_assert.sv
`timescale 1ns/10ps
module split_cache_assert (
	input logic clk,
	input logic reset_n,
	input logic i_irsp_valid,
	input logic i_ibusy,
	input logic i_drsp_valid,
	input logic i_dbusy,
	input logic i_imem_req_valid,
	input logic i_imem_done,
	input logic i_dmem_req_valid,
	input logic i_dmem_done
);
	logic ifill_pending;
	logic dfill_pending;
	// high once a reset edge has already passed
	logic reset_seen;

	initial begin
		reset_seen = 1'b0;
	end

	always @(posedge clk) begin
		reset_seen <= !reset_n;
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ifill_pending <= 1'b0;
			dfill_pending <= 1'b0;
		end else begin
			if (i_imem_req_valid) begin
				ifill_pending <= 1'b1;
			end else if (i_imem_done) begin
				ifill_pending <= 1'b0;
			end
			if (i_dmem_req_valid) begin
				dfill_pending <= 1'b1;
			end else if (i_dmem_done) begin
				dfill_pending <= 1'b0;
			end
		end
	end

	a_irsp_idle: assert property (@(posedge clk) disable iff (!reset_n)
		i_irsp_valid |-> !i_ibusy)
		else $error("instruction response while the icache is busy");
	a_drsp_idle: assert property (@(posedge clk) disable iff (!reset_n)
		i_drsp_valid |-> !i_dbusy)
		else $error("data response while the dcache is busy");
	a_imem_single: assert property (@(posedge clk) disable iff (!reset_n)
		i_imem_req_valid |-> !ifill_pending)
		else $error("second line request on the instruction port");
	a_dmem_single: assert property (@(posedge clk) disable iff (!reset_n)
		i_dmem_req_valid |-> !dfill_pending)
		else $error("second line request on the data port");
	a_reset_quiet: assert property (@(posedge clk)
		(!reset_n && reset_seen) |-> !(i_irsp_valid || i_drsp_valid || i_imem_req_valid
			|| i_dmem_req_valid || i_imem_done || i_dmem_done))
		else $error("strobe high during reset");

endmodule

bind split_cache_top split_cache_assert u_assert (
	.clk              (clk),
	.reset_n          (reset_n),
	.i_irsp_valid     (o_irsp_valid),
	.i_ibusy          (o_ibusy),
	.i_drsp_valid     (o_drsp_valid),
	.i_dbusy          (o_dbusy),
	.i_imem_req_valid (imem_req_valid),
	.i_imem_done      (imem_done),
	.i_dmem_req_valid (dmem_req_valid),
	.i_dmem_done      (dmem_done)
);

// File: tb/split_cache_tb.sv
`timescale 1ns/10ps
module split_cache_tb;
	import cache_pkg::*;

	localparam int RAND_DOPS       = 500;
	localparam int RAND_IOPS       = 200;
	localparam int OPS_TOTAL       = 256 + 256 + 5 + 4 + RAND_DOPS + RAND_IOPS;
	localparam int WATCHDOG_CYCLES = 400 * OPS_TOTAL;

	// has_data is clear when the expected response is a write ack
	typedef struct packed {
		addr_t addr;
		logic  has_data;
		word_t data;
	} expect_t;

	logic   clk;
	logic   reset_n;
	logic   i_ireq_valid;
	ireq_t  i_ireq;
	logic   o_irsp_valid;
	word_t  o_irsp_data;
	logic   o_ibusy;
	logic   i_dreq_valid;
	dreq_t  i_dreq;
	logic   o_drsp_valid;
	word_t  o_drsp_data;
	logic   o_dbusy;

	word_t   model [MEM_WORDS];
	expect_t iexp_q[$];
	expect_t dexp_q[$];
	dreq_t   rand_dops [RAND_DOPS];
	addr_t   rand_iaddr [RAND_IOPS];
	integer  seed;
	int      error_count;
	int      check_count;
	int      test_num;
	int      test_errors_base;

	split_cache_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic word_t ref_word(addr_t a);
		return model[a[7:0]];
	endfunction

	task automatic check_word(input string what, input word_t got, input word_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED %0t: %s returned %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_idle(input string what, input logic got);
		check_count++;
		if (got !== 1'b0) begin
			error_count++;
			$display("FAILED %0t: %s is %b, expected low", $time, what, got);
		end
	endtask

	// issue one fetch and hold it until the response shows up
	task automatic icache_fetch(input addr_t addr);
		iexp_q.push_back('{addr: addr, has_data: 1'b1, data: ref_word(addr)});
		i_ireq_valid = 1'b1;
		i_ireq.addr  = addr;
		@(negedge clk);
		while (!o_irsp_valid) @(negedge clk);
		i_ireq_valid = 1'b0;
	endtask

	task automatic dcache_access(input addr_t addr, input logic write, input word_t wdata);
		if (write) begin
			dexp_q.push_back('{addr: addr, has_data: 1'b0, data: '0});
			model[addr[7:0]] = wdata;
		end else begin
			dexp_q.push_back('{addr: addr, has_data: 1'b1, data: ref_word(addr)});
		end
		i_dreq_valid = 1'b1;
		i_dreq       = '{addr: addr, wdata: wdata, write: write};
		@(negedge clk);
		while (!o_drsp_valid) @(negedge clk);
		i_dreq_valid = 1'b0;
	endtask

	task automatic start_test();
		test_num++;
		test_errors_base = error_count;
	endtask

	task automatic finish_test(input string name);
		int errs;
		@(negedge clk);
		if (iexp_q.size() != 0 || dexp_q.size() != 0) begin
			error_count++;
			$display("test %0d: requests left without a response", test_num);
		end
		errs = error_count - test_errors_base;
		if (errs == 0) begin
			$display("test %0d %s: ok", test_num, name);
		end else begin
			$display("test %0d %s: %0d errors", test_num, name, errs);
		end
	endtask

	// responses are stable mid-cycle, so compare on the falling edge
	always @(negedge clk) begin : compare_responses
		expect_t e;
		if (o_irsp_valid) begin
			if (iexp_q.size() == 0) begin
				error_count++;
				$display("instruction response at %0t with no fetch pending", $time);
			end else begin
				e = iexp_q.pop_front();
				check_word($sformatf("ifetch %h", e.addr), o_irsp_data, e.data);
			end
		end
		if (o_drsp_valid) begin
			if (dexp_q.size() == 0) begin
				error_count++;
				$display("data response at %0t with no access pending", $time);
			end else begin
				e = dexp_q.pop_front();
				if (e.has_data) begin
					check_word($sformatf("dread %h", e.addr), o_drsp_data, e.data);
				end
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		logic [31:0] r;
		reset_n      = 1'b0;
		i_ireq_valid = 1'b0;
		i_ireq       = '0;
		i_dreq_valid = 1'b0;
		i_dreq       = '0;
		error_count  = 0;
		check_count  = 0;
		test_num     = 0;
		seed         = 32'he75ed5c1;
		$readmemh("hw/mem_init.hex", model);
		repeat (8) @(negedge clk);
		reset_n = 1'b1;

		start_test();
		check_idle("o_ibusy", o_ibusy);
		check_idle("o_dbusy", o_dbusy);
		check_idle("o_irsp_valid", o_irsp_valid);
		check_idle("o_drsp_valid", o_drsp_valid);
		finish_test("reset state");

		start_test();
		for (int a = 0; a < MEM_WORDS; a++) icache_fetch(addr_t'(a));
		finish_test("instruction sweep");

		start_test();
		for (int a = 0; a < MEM_WORDS; a++) dcache_access(addr_t'(a), 1'b0, '0);
		finish_test("data read sweep");

		start_test();
		dcache_access(16'h0045, 1'b1, 16'h1234);
		dcache_access(16'h0045, 1'b0, '0);
		dcache_access(16'h0044, 1'b0, '0);
		dcache_access(16'h0046, 1'b0, '0);
		dcache_access(16'h0047, 1'b0, '0);
		finish_test("write then read");

		// 0x10 and 0x30 share index 4 with different tags
		start_test();
		dcache_access(16'h0010, 1'b1, 16'hbeef);
		dcache_access(16'h0030, 1'b0, '0);
		dcache_access(16'h0010, 1'b0, '0);
		dcache_access(16'h0030, 1'b0, '0);
		finish_test("dirty eviction");

		// data writes stay below 0x80 and fetches stay above it
		for (int i = 0; i < RAND_DOPS; i++) begin
			r = $random(seed);
			rand_dops[i].write = r[0];
			rand_dops[i].addr  = r[0] ? {9'h0, r[14:8]} : {8'h0, r[15:8]};
			rand_dops[i].wdata = r[31:16];
		end
		for (int i = 0; i < RAND_IOPS; i++) begin
			r = $random(seed);
			rand_iaddr[i] = {8'h0, 1'b1, r[6:0]};
		end
		start_test();
		fork
			begin
				for (int i = 0; i < RAND_DOPS; i++) begin
					dcache_access(rand_dops[i].addr, rand_dops[i].write, rand_dops[i].wdata);
				end
			end
			begin
				for (int i = 0; i < RAND_IOPS; i++) icache_fetch(rand_iaddr[i]);
			end
		join
		finish_test("random mix");

		$display("%0d tests, %0d checks, %0d errors", test_num, check_count, error_count);
		if (error_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: src.f
hw/cache_pkg.sv
hw/icache.sv
hw/dcache.sv
hw/line_memory.sv
hw/split_cache_top.sv
tb/split_cache_assert.sv
tb/split_cache_tb.sv

// File: run.sh
#!/bin/sh
# builds the split cache testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f src.f --top-module split_cache_tb \
	-Mdir obj_dir -o split_cache_sim; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/split_cache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
	exit 1
fi

if ! grep -q ">>> PASS" "$LOG"; then
	echo "simulation log holds no pass line"
	exit 1
fi
exit 0

// File: hw/mem_init.hex
// one 16-bit word per entry, eight words per row; row k holds addresses 8k to 8k+7
ff00 fe01 fd02 fc03 fb04 fa05 f906 f807
f708 f609 f50a f40b f30c f20d f10e f00f
ef10 ee11 ed12 ec13 eb14 ea15 e916 e817
e718 e619 e51a e41b e31c e21d e11e e01f
df20 de21 dd22 dc23 db24 da25 d926 d827
d728 d629 d52a d42b d32c d22d d12e d02f
cf30 ce31 cd32 cc33 cb34 ca35 c936 c837
c738 c639 c53a c43b c33c c23d c13e c03f
bf40 be41 bd42 bc43 bb44 ba45 b946 b847
b748 b649 b54a b44b b34c b24d b14e b04f
af50 ae51 ad52 ac53 ab54 aa55 a956 a857
a758 a659 a55a a45b a35c a25d a15e a05f
9f60 9e61 9d62 9c63 9b64 9a65 9966 9867
9768 9669 956a 946b 936c 926d 916e 906f
8f70 8e71 8d72 8c73 8b74 8a75 8976 8877
8778 8679 857a 847b 837c 827d 817e 807f
7f80 7e81 7d82 7c83 7b84 7a85 7986 7887
7788 7689 758a 748b 738c 728d 718e 708f
6f90 6e91 6d92 6c93 6b94 6a95 6996 6897
6798 6699 659a 649b 639c 629d 619e 609f
5fa0 5ea1 5da2 5ca3 5ba4 5aa5 59a6 58a7
57a8 56a9 55aa 54ab 53ac 52ad 51ae 50af
4fb0 4eb1 4db2 4cb3 4bb4 4ab5 49b6 48b7
47b8 46b9 45ba 44bb 43bc 42bd 41be 40bf
3fc0 3ec1 3dc2 3cc3 3bc4 3ac5 39c6 38c7
37c8 36c9 35ca 34cb 33cc 32cd 31ce 30cf
2fd0 2ed1 2dd2 2cd3 2bd4 2ad5 29d6 28d7
27d8 26d9 25da 24db 23dc 22dd 21de 20df
1fe0 1ee1 1de2 1ce3 1be4 1ae5 19e6 18e7
17e8 16e9 15ea 14eb 13ec 12ed 11ee 10ef
0ff0 0ef1 0df2 0cf3 0bf4 0af5 09f6 08f7
07f8 06f9 05fa 04fb 03fc 02fd 01fe 00ff
